//--- vlog.f
src/mem_arb_pkg.sv
src/mem_link_if.sv
src/req_queue.sv
src/cmd_arbiter.sv
src/sram_bank.sv
src/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  # Design, in compile order.
  - src/mem_arb_pkg.sv
  - src/mem_link_if.sv
  - src/req_queue.sv
  - src/cmd_arbiter.sv
  - src/sram_bank.sv
  - src/mem_subsys_top.sv

  # Testbench.
  - target: test
    files:
      - verification/tb_mem_subsys.sv

//--- verification/mem_golden.txt
// client(0=i,1=d) group addr wen wdata wmask | expected: error errty rdata
// One record per line, every field in hex; equal group tags issue together.
1 01 00000010 1 11223344 f 0 0 00000000
1 02 00000014 1 a5a5a5a5 f 0 0 00000000
1 03 00000010 0 00000000 0 0 0 11223344
1 04 00000010 1 0000ee00 2 0 0 00000000
1 05 00000010 0 00000000 0 0 0 1122ee44
1 06 00000014 1 77000066 9 0 0 00000000
1 07 00000014 0 00000000 0 0 0 77a5a566
1 08 00000100 1 cafef00d f 0 0 00000000
0 09 00000100 0 00000000 0 0 0 cafef00d
0 0a 00000010 0 00000000 0 0 0 1122ee44
1 0b 00000102 1 deadbeef f 1 2 00000000
0 0c 00000401 0 00000000 0 1 2 00000000
1 0d 00000000 1 0badc0de f 0 0 00000000
1 0e 00000400 1 12345678 f 1 1 00000000
0 0f 00000ffc 0 00000000 0 1 1 00000000
1 10 00000000 0 00000000 0 0 0 0badc0de
1 11 00000100 0 00000000 0 0 0 cafef00d
0 12 00000014 0 00000000 0 0 0 77a5a566
1 12 00000020 1 55aa55aa f 0 0 00000000
0 13 00000010 0 00000000 0 0 0 1122ee44
1 13 00000100 0 00000000 0 0 0 cafef00d
1 14 00000030 1 13579bdf f 0 0 00000000
1 15 00000030 0 00000000 0 0 0 13579bdf
1 16 00000020 0 00000000 0 0 0 55aa55aa
0 17 00000030 0 00000000 0 0 0 13579bdf

//--- verification/tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys;
    import mem_arb_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int N_REC        = 25;
    localparam int REC_W        = 9;   // Words per golden record.

    // Field offsets inside one record.
    localparam int F_CLIENT = 0;
    localparam int F_TAG    = 1;
    localparam int F_ADDR   = 2;
    localparam int F_WEN    = 3;
    localparam int F_WDATA  = 4;
    localparam int F_WMASK  = 5;
    localparam int F_ERR    = 6;
    localparam int F_ERRTY  = 7;
    localparam int F_RDATA  = 8;

    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_REC * (MEM_LATENCY + 8);

    logic              clk;
    logic              arst_n;
    logic              i_req_valid;
    logic              i_req_ready;
    logic [ADDR_W-1:0] i_addr;
    logic              i_wen;
    logic [DATA_W-1:0] i_wdata;
    logic [MASK_W-1:0] i_wmask;
    logic              i_resp_valid;
    logic              i_resp_error;
    err_type_t         i_resp_errty;
    logic [DATA_W-1:0] i_resp_rdata;
    logic              d_req_valid;
    logic              d_req_ready;
    logic [ADDR_W-1:0] d_addr;
    logic              d_wen;
    logic [DATA_W-1:0] d_wdata;
    logic [MASK_W-1:0] d_wmask;
    logic              d_resp_valid;
    logic              d_resp_error;
    err_type_t         d_resp_errty;
    logic [DATA_W-1:0] d_resp_rdata;

    logic [31:0] vec [N_REC*REC_W];
    int          i_exp [$];  // Record indices waiting for a response.
    int          d_exp [$];
    int          rec;
    int          i_rec;
    int          d_rec;
    bit          i_taken;
    bit          d_taken;
    bit          running;
    bit          saw_full;   // Data queue pushed back at least once.

    mem_subsys_top mem_subsys_top_i (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s.", what);
        end
    endtask

    task automatic check_resp(input string side, input int r, input logic error,
                              input logic [1:0] errty, input logic [DATA_W-1:0] rdata);
        int base;
        base = r * REC_W;
        check_value({side, " resp_error"}, error, vec[base + F_ERR]);
        check_value({side, " resp_errty"}, errty, vec[base + F_ERRTY]);
        check_value({side, " resp_rdata"}, rdata, vec[base + F_RDATA]);
    endtask

    // Outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (running) begin
            if (!d_req_ready) saw_full = 1'b1;
            if (i_resp_valid) begin
                check_value("i resp_valid", (i_exp.size() != 0), 32'd1);  // Must be ours.
                check_resp("i", i_exp.pop_front(), i_resp_error, i_resp_errty, i_resp_rdata);
            end
            if (d_resp_valid) begin
                check_value("d resp_valid", (d_exp.size() != 0), 32'd1);
                check_resp("d", d_exp.pop_front(), d_resp_error, d_resp_errty, d_resp_rdata);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_record(input int r);
        int base;
        base = r * REC_W;
        if (vec[base + F_CLIENT] == 32'd0) begin
            i_addr      = vec[base + F_ADDR];
            i_wen       = vec[base + F_WEN][0];
            i_wdata     = vec[base + F_WDATA];
            i_wmask     = vec[base + F_WMASK][MASK_W-1:0];
            i_req_valid = 1'b1;
            i_rec       = r;
        end else begin
            d_addr      = vec[base + F_ADDR];
            d_wen       = vec[base + F_WEN][0];
            d_wdata     = vec[base + F_WDATA];
            d_wmask     = vec[base + F_WMASK][MASK_W-1:0];
            d_req_valid = 1'b1;
            d_rec       = r;
        end
    endtask

    task automatic load_group();
        int last;
        int r;
        bit has_i;
        bit has_d;
        last  = rec;
        has_i = 1'b0;
        has_d = 1'b0;
        while (last + 1 < N_REC && vec[(last+1)*REC_W + F_TAG] == vec[rec*REC_W + F_TAG])
            last++;
        for (r = rec; r <= last; r++) begin
            if (vec[r*REC_W + F_CLIENT] == 32'd0) has_i = 1'b1;
            else has_d = 1'b1;
        end
        // The two clients' responses are not ordered against each other.
        if ((has_i && d_exp.size() != 0) || (has_d && i_exp.size() != 0)) return;
        for (r = rec; r <= last; r++) drive_record(r);
        rec = last + 1;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        i_req_valid = 1'b0;
        i_addr      = '0;
        i_wen       = 1'b0;
        i_wdata     = '0;
        i_wmask     = '0;
        d_req_valid = 1'b0;
        d_addr      = '0;
        d_wen       = 1'b0;
        d_wdata     = '0;
        d_wmask     = '0;
        running     = 1'b0;
        saw_full    = 1'b0;
        i_taken     = 1'b0;
        d_taken     = 1'b0;
        rec         = 0;
        $readmemh("verification/mem_golden.txt", vec);

        repeat (RESET_CYCLES) @(negedge clk);
        // Queues and bank hold off while in reset.
        check_value("i_req_ready in reset", i_req_ready, 32'd0);
        check_value("d_req_ready in reset", d_req_ready, 32'd0);
        check_value("i_resp_valid in reset", i_resp_valid, 32'd0);
        check_value("d_resp_valid in reset", d_resp_valid, 32'd0);
        arst_n = 1'b1;
        @(negedge clk);
        running = 1'b1;

        while (rec < N_REC || i_req_valid || d_req_valid) begin
            @(negedge clk);
            if (i_req_valid && i_taken) i_req_valid = 1'b0;  // Went in at the last edge.
            if (d_req_valid && d_taken) d_req_valid = 1'b0;
            if (!i_req_valid && !d_req_valid && rec < N_REC) load_group();
            // Ready only moves on the rising edge.
            i_taken = i_req_valid && i_req_ready;
            d_taken = d_req_valid && d_req_ready;
            if (i_taken) i_exp.push_back(i_rec);
            if (d_taken) d_exp.push_back(d_rec);
        end

        while (i_exp.size() != 0 || d_exp.size() != 0) @(negedge clk);
        repeat (10) @(negedge clk);  // Catch stray pulses.
        check_value("d_req_ready dropped during burst", saw_full, 32'd1);

        $display("TEST PASSED");
        $finish;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: responses never arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired.");
    end

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                           clk,
    input  logic                           arst_n,
    // Instruction client.
    input  logic                           i_req_valid,
    output logic                           i_req_ready,
    input  logic [mem_arb_pkg::ADDR_W-1:0] i_addr,
    input  logic                           i_wen,
    input  logic [mem_arb_pkg::DATA_W-1:0] i_wdata,
    input  logic [mem_arb_pkg::MASK_W-1:0] i_wmask,
    output logic                           i_resp_valid,
    output logic                           i_resp_error,
    output mem_arb_pkg::err_type_t         i_resp_errty,
    output logic [mem_arb_pkg::DATA_W-1:0] i_resp_rdata,
    // Data client.
    input  logic                           d_req_valid,
    output logic                           d_req_ready,
    input  logic [mem_arb_pkg::ADDR_W-1:0] d_addr,
    input  logic                           d_wen,
    input  logic [mem_arb_pkg::DATA_W-1:0] d_wdata,
    input  logic [mem_arb_pkg::MASK_W-1:0] d_wmask,
    output logic                           d_resp_valid,
    output logic                           d_resp_error,
    output mem_arb_pkg::err_type_t         d_resp_errty,
    output logic [mem_arb_pkg::DATA_W-1:0] d_resp_rdata
);

    mem_link_if i_link ();  // Instruction queue to arbiter.
    mem_link_if d_link ();  // Data queue to arbiter.
    mem_link_if m_link ();  // Arbiter to bank.

    req_queue i_queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (i_req_valid),
        .addr       (i_addr),
        .wen        (i_wen),
        .wdata      (i_wdata),
        .wmask      (i_wmask),
        .req_ready  (i_req_ready),
        .resp_valid (i_resp_valid),
        .resp_error (i_resp_error),
        .resp_errty (i_resp_errty),
        .resp_rdata (i_resp_rdata),
        .link       (i_link.requester)
    );

    req_queue d_queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (d_req_valid),
        .addr       (d_addr),
        .wen        (d_wen),
        .wdata      (d_wdata),
        .wmask      (d_wmask),
        .req_ready  (d_req_ready),
        .resp_valid (d_resp_valid),
        .resp_error (d_resp_error),
        .resp_errty (d_resp_errty),
        .resp_rdata (d_resp_rdata),
        .link       (d_link.requester)
    );

    cmd_arbiter cmd_arbiter_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ilink  (i_link.server),
        .dlink  (d_link.server),
        .mlink  (m_link.requester)
    );

    sram_bank sram_bank_i (
        .clk    (clk),
        .arst_n (arst_n),
        .link   (m_link.server)
    );

endmodule

//--- src/sram_bank.sv
`timescale 1ns/100ps

module sram_bank (
    input  logic       clk,
    input  logic       arst_n,
    mem_link_if.server link
);
    import mem_arb_pkg::*;

    logic [DATA_W-1:0]      mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0]   idx;
    err_type_t              errty;
    logic                   accept;
    logic                   alive;
    logic                   busy;

    // Access stage, loaded at the accept edge.
    logic                   acc_valid;
    mem_resp_t              acc_resp;

    // Delay line toward the response port.
    logic [MEM_LATENCY-1:0] pipe_valid;
    mem_resp_t              pipe_resp [MEM_LATENCY];

    assign busy           = acc_valid || (|pipe_valid);
    assign link.req_ready = alive && !busy;  // One command in flight.
    assign accept         = link.req_valid && link.req_ready;
    assign idx            = link.req.addr[MEM_IDX_W+1:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address check.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (link.req.addr[1:0] != 2'b00) begin
            errty = ERR_ALIGN;
        end else if (link.req.addr[ADDR_W-1:2] >= MEM_WORDS) begin
            errty = ERR_RANGE;
        end else begin
            errty = ERR_NONE;
        end
    end

    // Byte-masked write; bad addresses leave the array alone.
    always_ff @(posedge clk) begin
        if (accept && link.req.wen && errty == ERR_NONE) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (link.req.wmask[b]) mem[idx][8*b +: 8] <= link.req.wdata[8*b +: 8];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response pipeline.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_resp.error <= (errty != ERR_NONE);
            acc_resp.errty <= errty;
            if (link.req.wen || errty != ERR_NONE) acc_resp.rdata <= '0;
            else acc_resp.rdata <= mem[idx];  // Old word, before any write.
        end
        pipe_resp[0] <= acc_resp;
        for (int s = 1; s < MEM_LATENCY; s++) begin
            pipe_resp[s] <= pipe_resp[s-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alive      <= 1'b0;
            acc_valid  <= 1'b0;
            pipe_valid <= '0;
        end else begin
            alive         <= 1'b1;
            acc_valid     <= accept;
            pipe_valid[0] <= acc_valid;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    assign link.resp_valid = pipe_valid[MEM_LATENCY-1];
    assign link.resp       = pipe_resp[MEM_LATENCY-1];

endmodule

//--- src/cmd_arbiter.sv
`timescale 1ns/100ps

module cmd_arbiter (
    input  logic          clk,
    input  logic          arst_n,
    mem_link_if.server    ilink,
    mem_link_if.server    dlink,
    mem_link_if.requester mlink
);
    import mem_arb_pkg::*;

    typedef enum logic [2:0] {
        I_CHECK,
        I_READY,
        I_VALID,
        D_CHECK,
        D_READY,
        D_VALID
    } state_t;

    state_t   state;
    mem_req_t s_ireq;  // Held copy while memory is busy.
    mem_req_t s_dreq;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Client side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ilink.req_ready = (state == I_CHECK);
    assign dlink.req_ready = (state == D_CHECK);

    // Only the owning side sees the pulse.
    assign ilink.resp_valid = (state == I_VALID) && mlink.resp_valid;
    assign dlink.resp_valid = (state == D_VALID) && mlink.resp_valid;
    assign ilink.resp       = mlink.resp;
    assign dlink.resp       = mlink.resp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory command.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mlink.req_valid = (state == I_READY) || (state == D_READY)
                           || ((state == I_CHECK) && ilink.req_valid)
                           || ((state == D_CHECK) && dlink.req_valid);

    always_comb begin
        case (state)
            I_CHECK: mlink.req = ilink.req;  // Straight through.
            D_CHECK: mlink.req = dlink.req;
            I_READY: mlink.req = s_ireq;
            D_READY: mlink.req = s_dreq;
            default: mlink.req = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == I_CHECK && ilink.req_valid) s_ireq <= ilink.req;
        if (state == D_CHECK && dlink.req_valid) s_dreq <= dlink.req;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Turn and transaction tracking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= I_CHECK;  // Instruction side goes first.
        end else begin
            case (state)
                I_CHECK: begin
                    if (!ilink.req_valid) state <= D_CHECK;
                    else if (mlink.req_ready) state <= I_VALID;
                    else state <= I_READY;
                end
                I_READY: begin
                    if (mlink.req_ready) state <= I_VALID;
                end
                I_VALID: begin
                    if (mlink.resp_valid) state <= D_CHECK;
                end
                D_CHECK: begin
                    if (!dlink.req_valid) state <= I_CHECK;
                    else if (mlink.req_ready) state <= D_VALID;
                    else state <= D_READY;
                end
                D_READY: begin
                    if (mlink.req_ready) state <= D_VALID;
                end
                D_VALID: begin
                    if (mlink.resp_valid) state <= I_CHECK;
                end
                default: state <= I_CHECK;  // Unused codes recover.
            endcase
        end
    end

endmodule

//--- src/req_queue.sv
`timescale 1ns/100ps

module req_queue (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           req_valid,
    input  logic [mem_arb_pkg::ADDR_W-1:0] addr,
    input  logic                           wen,
    input  logic [mem_arb_pkg::DATA_W-1:0] wdata,
    input  logic [mem_arb_pkg::MASK_W-1:0] wmask,
    output logic                           req_ready,
    output logic                           resp_valid,
    output logic                           resp_error,
    output mem_arb_pkg::err_type_t         resp_errty,
    output logic [mem_arb_pkg::DATA_W-1:0] resp_rdata,
    mem_link_if.requester                  link
);
    import mem_arb_pkg::*;

    mem_req_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       alive;  // Set from the first edge after reset.
    logic       push;
    logic       pop;

    assign req_ready      = alive && (count != 2'd2);
    assign push           = req_valid && req_ready;
    assign pop            = link.req_valid && link.req_ready;

    assign link.req_valid = (count != 2'd0);
    assign link.req       = entry[rd_ptr];  // Head entry.

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= '{addr: addr, wen: wen, wdata: wdata, wmask: wmask};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alive  <= 1'b0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            alive <= 1'b1;
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            if (push && !pop) count <= count + 2'd1;
            else if (pop && !push) count <= count - 2'd1;
        end
    end

    // Responses go straight out.
    assign resp_valid = link.resp_valid;
    assign resp_error = link.resp.error;
    assign resp_errty = link.resp.errty;
    assign resp_rdata = link.resp.rdata;

endmodule

//--- src/mem_link_if.sv
`timescale 1ns/100ps

interface mem_link_if;
    import mem_arb_pkg::*;

    // Request channel.
    logic      req_valid;
    logic      req_ready;
    mem_req_t  req;

    // Response channel, a bare valid pulse.
    logic      resp_valid;
    mem_resp_t resp;

    modport requester (
        output req_valid,
        output req,
        input  req_ready,
        input  resp_valid,
        input  resp
    );

    modport server (
        input  req_valid,
        input  req,
        output req_ready,
        output resp_valid,
        output resp
    );

endinterface

//--- src/mem_arb_pkg.sv
package mem_arb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and memory geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W      = 32;  // Byte address.
    localparam int DATA_W      = 32;
    localparam int MASK_W      = DATA_W / 8;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 2;   // Accept edge to response cycle.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and response payloads.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Alignment errors win over range errors.
    typedef enum logic [1:0] {
        ERR_NONE  = 2'd0,
        ERR_RANGE = 2'd1,
        ERR_ALIGN = 2'd2
    } err_type_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              wen;    // Write when set.
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] wmask;  // One bit per byte lane.
    } mem_req_t;

    typedef struct packed {
        logic              error;
        err_type_t         errty;
        logic [DATA_W-1:0] rdata;  // Zero for writes.
    } mem_resp_t;

endpackage
